/* sim.f */
src/mbist_cfg_pkg.sv
src/ser_access_if.sv
src/mbist_cfg_regs.sv
src/mbist_ser_fsm.sv
src/mbist_shift_cnt.sv
src/mbist_ser_shifter.sv
src/mbist_cfg_top.sv
verification/tb_mbist_cfg.sv

/* Bender.yml */
package:
  name: mbist_cfg

sources:
  # Package and interface first, then the modules that use them
  - src/mbist_cfg_pkg.sv
  - src/ser_access_if.sv
  - src/mbist_cfg_regs.sv
  - src/mbist_ser_fsm.sv
  - src/mbist_shift_cnt.sv
  - src/mbist_ser_shifter.sv
  - src/mbist_cfg_top.sv

  - target: simulation
    files:
      - verification/tb_mbist_cfg.sv

/* verification/tb_mbist_cfg.sv */
// Testbench for the MBIST config block with bus tasks, channel chain model and checks
`timescale 1ns/100ps

module tb_mbist_cfg;
    import mbist_cfg_pkg::*;

    localparam int CLK_HALF  = 4;
    localparam int ACK_LIMIT = 200;
    localparam int NUM_RAND  = 40;

    logic                          mclk;
    logic                          reset_n;
    logic                          reg_cs;
    logic                          reg_wr;
    logic [ADDR_W-1:0]             reg_addr;
    reg_word_t                     reg_wdata;
    logic [BE_W-1:0]               reg_be;
    reg_word_t                     reg_rdata;
    logic                          reg_ack;
    ch_vec_t                       bist_en;
    ch_vec_t                       bist_run;
    ch_vec_t                       bist_load;
    ch_vec_t                       bist_sdi;
    ch_vec_t                       bist_shift;
    ch_vec_t                       bist_sdo;
    ch_vec_t                       bist_done;
    ch_vec_t                       bist_error;
    ch_vec_t                       bist_correct;
    logic [NUM_CH*ERR_CNT_W-1:0]   bist_error_cnt;

    // Channel chain model and its expected contents
    reg_word_t chains [NUM_CH];
    reg_word_t chain_init [NUM_CH];
    reg_word_t exp_chain [NUM_CH];
    int        shift_total [NUM_CH];
    // Channels allowed to see bist_shift right now
    ch_vec_t   shift_allow;
    // Register model, indexed like the register map
    reg_word_t reg_ref [16];
    integer    seed;
    int        err_cnt;
    int        chk_cnt;
    int        test_err0;

    mbist_cfg_top UUT (
        .mclk           (mclk),
        .reset_n        (reset_n),
        .reg_cs         (reg_cs),
        .reg_wr         (reg_wr),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_be         (reg_be),
        .reg_rdata      (reg_rdata),
        .reg_ack        (reg_ack),
        .bist_en        (bist_en),
        .bist_run       (bist_run),
        .bist_load      (bist_load),
        .bist_sdi       (bist_sdi),
        .bist_shift     (bist_shift),
        .bist_sdo       (bist_sdo),
        .bist_done      (bist_done),
        .bist_error     (bist_error),
        .bist_correct   (bist_correct),
        .bist_error_cnt (bist_error_cnt)
    );

    initial begin
        mclk = 1'b0;
        forever begin
            #CLK_HALF mclk = ~mclk;
        end
    end

    // ----------------------------------------------------------
    // Channel chains
    // ----------------------------------------------------------
    // sdo is bit 0, sdi enters at bit 31
    for (genvar g = 0; g < NUM_CH; g++) begin : g_sdo
        assign bist_sdo[g] = reset_n ? chains[g][0] : 1'b0;
    end

    always @(posedge mclk or negedge reset_n) begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (!reset_n) begin
                chains[ch]      <= chain_init[ch];
                shift_total[ch] <= 0;
            end else if (bist_shift[ch]) begin
                chains[ch]      <= {bist_sdi[ch], chains[ch][DATA_W-1:1]};
                shift_total[ch] <= shift_total[ch] + 1;
            end
        end
    end

    // ----------------------------------------------------------
    // Reference functions
    // ----------------------------------------------------------
    function automatic reg_word_t reset_ref(input logic [3:0] idx);
        case (idx)
            REG_SCRATCH0: return RST_SCRATCH0;
            REG_SCRATCH1: return RST_SCRATCH1;
            REG_CHIP_ID:  return RST_CHIP_ID;
            REG_REL_DATE: return RST_REL_DATE;
            REG_REVISION: return RST_REVISION;
            default:      return '0;
        endcase
    endfunction

    // Byte mask from the enables, then blend
    function automatic reg_word_t merge_ref(input reg_word_t old_val, input reg_word_t new_val,
                                            input logic [3:0] be);
        reg_word_t mask;
        for (int b = 0; b < BE_W; b++) begin
            mask[8*b +: 8] = {8{be[b]}};
        end
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // Four status bytes, channels 4 to 7 when hi is set
    function automatic reg_word_t status_ref(input logic hi, input ch_vec_t done,
                                             input ch_vec_t err, input ch_vec_t corr,
                                             input logic [NUM_CH*ERR_CNT_W-1:0] cnt);
        reg_word_t w;
        int        ch;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            ch = hi ? k + 4 : k;
            w[8*k]        = done[ch];
            w[8*k+1]      = err[ch];
            w[8*k+2]      = corr[ch];
            w[8*k+4 +: 4] = cnt[4*ch +: 4];
        end
        return w;
    endfunction

    // One control bit per channel nibble, pos 0 en, 1 run, 2 load
    function automatic ch_vec_t ctrl_bits(input reg_word_t ctrl, input int pos);
        ch_vec_t v;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            v[ch] = ctrl[4*ch+pos];
        end
        return v;
    endfunction

    function automatic int total_shifts();
        int sum;
        sum = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            sum += shift_total[ch];
        end
        return sum;
    endfunction

    // ----------------------------------------------------------
    // Checks and bus tasks
    // ----------------------------------------------------------
    task automatic check(input reg_word_t got, input reg_word_t exp, input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic bus_access(input logic wr, input logic [3:0] idx, input reg_word_t wdata,
                              input logic [3:0] be, output reg_word_t rdata);
        int   n;
        logic got;
        @(posedge mclk);
        #1;
        reg_cs    = 1'b1;
        reg_wr    = wr;
        reg_addr  = {2'b00, idx, 2'b00};
        reg_wdata = wdata;
        reg_be    = be;
        n         = 0;
        got       = 1'b0;
        // Serial accesses take 35 cycles or so
        while (!got && n < ACK_LIMIT) begin
            @(posedge mclk);
            #1;
            n++;
            got = reg_ack;
        end
        rdata  = reg_rdata;
        reg_cs = 1'b0;
        reg_wr = 1'b0;
        if (!got) begin
            err_cnt++;
            $display("Timeout at %0t: register %0d gave no reg_ack within %0d cycles",
                     $time, idx, ACK_LIMIT);
        end
    endtask

    // Select keeps only the low nibble of byte 0
    task automatic write_reg(input logic [3:0] idx, input reg_word_t data, input logic [3:0] be);
        reg_word_t unused;
        bus_access(1'b1, idx, data, be, unused);
        if (idx == REG_SER_SEL) begin
            if (be[0]) begin
                reg_ref[idx] = {28'd0, data[3:0]};
            end
        end else begin
            reg_ref[idx] = merge_ref(reg_ref[idx], data, be);
        end
    endtask

    task automatic read_check(input logic [3:0] idx, input reg_word_t exp, input string msg);
        reg_word_t got;
        bus_access(1'b0, idx, '0, 4'h0, got);
        check(got, exp, msg);
    endtask

    // Access returns the old chain, chain then holds the shifted-in word
    task automatic serial_xfer(input logic wr, input int ch, input reg_word_t w);
        reg_word_t got;
        reg_word_t exp;
        exp = (ch < NUM_CH) ? exp_chain[ch] : '0;
        bus_access(wr, wr ? REG_SER_WR : REG_SER_RD, w, 4'hF, got);
        check(got, exp, $sformatf("serial %s data on channel %0d", wr ? "write" : "read", ch));
        if (ch < NUM_CH) begin
            exp_chain[ch] = wr ? w : '0;
        end
    endtask

    task automatic compare_chains();
        for (int ch = 0; ch < NUM_CH; ch++) begin
            check(chains[ch], exp_chain[ch], $sformatf("chain %0d contents", ch));
        end
    endtask

    task automatic test_done(input string name);
        $display("Test %-16s %s, %0d errors", name,
                 (err_cnt == test_err0) ? "ok" : "mismatch", err_cnt - test_err0);
        test_err0 = err_cnt;
    endtask

    // Sampled mid-cycle, where all outputs are settled
    always @(negedge mclk) begin
        if (reset_n) begin
            check(32'(bist_shift & ~shift_allow), '0, "bist_shift outside selected channel");
            check(32'(bist_sdi & ~shift_allow), '0, "bist_sdi outside selected channel");
            check(32'(bist_en), 32'(ctrl_bits(reg_ref[REG_BIST_CTRL], 0)), "bist_en");
            check(32'(bist_run), 32'(ctrl_bits(reg_ref[REG_BIST_CTRL], 1)), "bist_run");
            check(32'(bist_load), 32'(ctrl_bits(reg_ref[REG_BIST_CTRL], 2)), "bist_load");
        end
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        reg_word_t  rnd;
        reg_word_t  w;
        reg_word_t  exp;
        logic [3:0] idx;
        int         k;
        int         base;
        seed           = 32'h3d4d;
        err_cnt        = 0;
        chk_cnt        = 0;
        test_err0      = 0;
        reset_n        = 1'b0;
        reg_cs         = 1'b0;
        reg_wr         = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        reg_be         = '0;
        shift_allow    = '0;
        rnd            = $random(seed);
        bist_done      = rnd[7:0];
        bist_error     = rnd[15:8];
        bist_correct   = rnd[23:16];
        bist_error_cnt = $random(seed);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            chain_init[ch] = $random(seed);
            exp_chain[ch]  = chain_init[ch];
        end
        for (int i = 0; i < 16; i++) begin
            reg_ref[i] = reset_ref(i[3:0]);
        end
        repeat (8) @(posedge mclk);
        #1;
        reset_n = 1'b1;

        // 1: reset values, index 7 skipped as it starts a serial read
        check({bist_en, bist_run, bist_load, bist_shift}, '0, "control outputs after reset");
        check(32'(bist_sdi), '0, "bist_sdi after reset");
        for (int i = 0; i < 16; i++) begin
            if (i != REG_SER_RD) begin
                if (i == REG_STATUS_LO || i == REG_STATUS_HI) begin
                    exp = status_ref(i == REG_STATUS_HI, bist_done, bist_error,
                                     bist_correct, bist_error_cnt);
                end else begin
                    exp = reset_ref(i[3:0]);
                end
                read_check(i[3:0], exp, $sformatf("reset value of register %0d", i));
            end
        end
        test_done("reset values");

        // 2: byte-merged writes, k maps onto indices 0 to 3 and 9 to 11
        for (int n = 0; n < NUM_RAND; n++) begin
            rnd = $random(seed);
            k   = int'(rnd[15:0]) % 7;
            idx = (k < 4) ? k[3:0] : k[3:0] + 4'd5;
            w   = $random(seed);
            write_reg(idx, w, rnd[19:16]);
            read_check(idx, reg_ref[idx], $sformatf("readback of register %0d", idx));
        end
        test_done("byte writes");

        // 3: control nibble split
        for (int n = 0; n < 8; n++) begin
            w = $random(seed);
            write_reg(REG_BIST_CTRL, w, 4'hF);
            check(32'(bist_en), 32'(ctrl_bits(w, 0)), "bist_en after control write");
            check(32'(bist_run), 32'(ctrl_bits(w, 1)), "bist_run after control write");
            check(32'(bist_load), 32'(ctrl_bits(w, 2)), "bist_load after control write");
        end
        test_done("control split");

        // 4: status packing
        for (int n = 0; n < 8; n++) begin
            @(posedge mclk);
            #1;
            rnd            = $random(seed);
            bist_done      = rnd[7:0];
            bist_error     = rnd[15:8];
            bist_correct   = rnd[23:16];
            bist_error_cnt = $random(seed);
            read_check(REG_STATUS_LO, status_ref(1'b0, bist_done, bist_error, bist_correct,
                       bist_error_cnt), "status low");
            read_check(REG_STATUS_HI, status_ref(1'b1, bist_done, bist_error, bist_correct,
                       bist_error_cnt), "status high");
        end
        test_done("status packing");

        // 5: serial write then read on every channel
        for (int ch = 0; ch < NUM_CH; ch++) begin
            write_reg(REG_SER_SEL, ch, 4'h1);
            shift_allow = ch_vec_t'(1) << ch;
            base        = shift_total[ch];
            w           = $random(seed);
            serial_xfer(1'b1, ch, w);
            serial_xfer(1'b0, ch, '0);
            read_check(REG_SER_LAST, w, $sformatf("last serial data on channel %0d", ch));
            // Leave a fresh word in the chain for the out of range test
            w = $random(seed);
            serial_xfer(1'b1, ch, w);
            shift_allow = '0;
            check(shift_total[ch] - base, 3 * SHIFT_LEN,
                  $sformatf("shift cycles on channel %0d", ch));
            compare_chains();
        end
        test_done("serial loop");

        // 6: out of range select shifts nothing and reads zero
        // Channel 7 is still selected, reading it makes the last serial data non-zero
        shift_allow = ch_vec_t'(1) << (NUM_CH - 1);
        serial_xfer(1'b0, NUM_CH - 1, '0);
        shift_allow = '0;
        write_reg(REG_SER_SEL, 32'd9, 4'h1);
        base = total_shifts();
        serial_xfer(1'b0, 9, '0);
        check(total_shifts() - base, 0, "shift cycles with select 9");
        read_check(REG_SER_LAST, '0, "last serial data with select 9");
        compare_chains();
        test_done("no channel");

        $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* src/mbist_cfg_top.sv */
// MBIST config and status block top with register bus and eight channel ports
`timescale 1ns/100ps

module mbist_cfg_top (
    input  logic                                   mclk,
    input  logic                                   reset_n,
    // Register bus
    input  logic                                   reg_cs,
    input  logic                                   reg_wr,
    input  logic [mbist_cfg_pkg::ADDR_W-1:0]       reg_addr,
    input  mbist_cfg_pkg::reg_word_t               reg_wdata,
    input  logic [mbist_cfg_pkg::BE_W-1:0]         reg_be,
    output mbist_cfg_pkg::reg_word_t               reg_rdata,
    output logic                                   reg_ack,
    // To the channels
    output mbist_cfg_pkg::ch_vec_t                 bist_en,
    output mbist_cfg_pkg::ch_vec_t                 bist_run,
    output mbist_cfg_pkg::ch_vec_t                 bist_load,
    output mbist_cfg_pkg::ch_vec_t                 bist_sdi,
    output mbist_cfg_pkg::ch_vec_t                 bist_shift,
    // From the channels
    input  mbist_cfg_pkg::ch_vec_t                 bist_sdo,
    input  mbist_cfg_pkg::ch_vec_t                 bist_done,
    input  mbist_cfg_pkg::ch_vec_t                 bist_error,
    input  mbist_cfg_pkg::ch_vec_t                 bist_correct,
    // Channel 0 in the low nibble
    input  logic [mbist_cfg_pkg::NUM_CH*mbist_cfg_pkg::ERR_CNT_W-1:0] bist_error_cnt
);

    logic [3:0] ser_sel;
    logic       load;
    logic       load_wr;
    logic       shift_en;
    logic       cnt_clr;
    logic       cnt_en;
    logic       last_bit;

    ser_access_if u_ser_if ();

    // ----------------------------------------------------------
    // Register block
    // ----------------------------------------------------------
    mbist_cfg_regs u_regs (
        .mclk           (mclk),
        .reset_n        (reset_n),
        .reg_cs         (reg_cs),
        .reg_wr         (reg_wr),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_be         (reg_be),
        .reg_rdata      (reg_rdata),
        .reg_ack        (reg_ack),
        .bist_done      (bist_done),
        .bist_error     (bist_error),
        .bist_correct   (bist_correct),
        .bist_error_cnt (bist_error_cnt),
        .bist_en        (bist_en),
        .bist_run       (bist_run),
        .bist_load      (bist_load),
        .ser_sel        (ser_sel),
        .ser            (u_ser_if)
    );

    // ----------------------------------------------------------
    // Serial engine
    // ----------------------------------------------------------
    mbist_ser_fsm u_ser_fsm (
        .mclk     (mclk),
        .reset_n  (reset_n),
        .last_bit (last_bit),
        .ser      (u_ser_if),
        .load     (load),
        .load_wr  (load_wr),
        .shift_en (shift_en),
        .cnt_clr  (cnt_clr),
        .cnt_en   (cnt_en)
    );

    mbist_shift_cnt u_shift_cnt (
        .mclk     (mclk),
        .reset_n  (reset_n),
        .cnt_clr  (cnt_clr),
        .cnt_en   (cnt_en),
        .last_bit (last_bit)
    );

    mbist_ser_shifter u_ser_shifter (
        .mclk       (mclk),
        .reset_n    (reset_n),
        .load       (load),
        .load_wr    (load_wr),
        .shift_en   (shift_en),
        .ser_sel    (ser_sel),
        .bist_sdo   (bist_sdo),
        .ser        (u_ser_if),
        .bist_sdi   (bist_sdi),
        .bist_shift (bist_shift)
    );

endmodule

/* src/mbist_ser_shifter.sv */
// Serial shift word with routing of sdi, shift and sdo to the selected channel
`timescale 1ns/100ps

module mbist_ser_shifter (
    input  logic                   mclk,
    input  logic                   reset_n,
    input  logic                   load,
    input  logic                   load_wr,
    input  logic                   shift_en,
    input  logic [3:0]             ser_sel,
    input  mbist_cfg_pkg::ch_vec_t bist_sdo,
    ser_access_if.shifter          ser,
    output mbist_cfg_pkg::ch_vec_t bist_sdi,
    output mbist_cfg_pkg::ch_vec_t bist_shift
);
    import mbist_cfg_pkg::*;

    reg_word_t shift_q;
    ch_vec_t   ch_hit;
    logic      sdo_sel;

    // ----------------------------------------------------------
    // Channel routing
    // ----------------------------------------------------------
    // Select of 8 or more hits no channel
    always_comb begin
        sdo_sel = 1'b0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            ch_hit[ch]     = (ser_sel == 4'(ch));
            bist_shift[ch] = shift_en & ch_hit[ch];
            bist_sdi[ch]   = shift_en & ch_hit[ch] & shift_q[0];
            sdo_sel        = sdo_sel | (ch_hit[ch] & bist_sdo[ch]);
        end
    end

    // ----------------------------------------------------------
    // Shift word
    // ----------------------------------------------------------
    // LSB goes out first, chain data enters at the top
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            shift_q <= '0;
        end else if (load) begin
            shift_q <= load_wr ? ser.wdata : '0;
        end else if (shift_en) begin
            shift_q <= {sdo_sel, shift_q[DATA_W-1:1]};
        end
    end

    assign ser.rdata = shift_q;

    // Only one chain may ever be clocked
    assert property (@(posedge mclk) disable iff (!reset_n) $onehot0(bist_shift));

endmodule

/* src/mbist_shift_cnt.sv */
// Shift bit counter that flags the last of the serial shift cycles
`timescale 1ns/100ps

module mbist_shift_cnt (
    input  logic mclk,
    input  logic reset_n,
    input  logic cnt_clr,
    input  logic cnt_en,
    output logic last_bit
);
    import mbist_cfg_pkg::*;

    logic [CNT_W-1:0] cnt_q;

    // Clear wins over count
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            cnt_q <= '0;
        end else if (cnt_clr) begin
            cnt_q <= '0;
        end else if (cnt_en) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Terminal count
    assign last_bit = (cnt_q == CNT_W'(SHIFT_LEN - 1));

    // Sequencer must stop counting once the terminal value is reached
    assert property (@(posedge mclk) disable iff (!reset_n)
        (cnt_en && last_bit) |=> !cnt_en);

endmodule

/* src/mbist_ser_fsm.sv */
// Serial access sequencer for load, 32 shift cycles and done strobe
`timescale 1ns/100ps

module mbist_ser_fsm (
    input  logic     mclk,
    input  logic     reset_n,
    input  logic     last_bit,
    ser_access_if.fsm ser,
    output logic     load,
    output logic     load_wr,
    output logic     shift_en,
    output logic     cnt_clr,
    output logic     cnt_en
);
    import mbist_cfg_pkg::*;

    ser_state_t state_q;
    ser_state_t state_d;

    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------------------------
    // Next state and outputs
    // ----------------------------------------------------------
    always_comb begin
        state_d  = state_q;
        load     = 1'b0;
        load_wr  = 1'b0;
        shift_en = 1'b0;
        cnt_clr  = 1'b0;
        cnt_en   = 1'b0;
        case (state_q)
            IDLE: begin
                if (ser.start_wr || ser.start_rd) begin
                    // Write loads bus data, read loads zero
                    load    = 1'b1;
                    load_wr = ser.start_wr;
                    cnt_clr = 1'b1;
                    state_d = SHIFT;
                end
            end
            SHIFT: begin
                shift_en = 1'b1;
                cnt_en   = 1'b1;
                if (last_bit) begin
                    state_d = DONE;
                end
            end
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // Done strobe for exactly one cycle
    assign ser.done = (state_q == DONE);

    // Register block decodes one index per access
    assert property (@(posedge mclk) disable iff (!reset_n) !(ser.start_wr && ser.start_rd));
    // Bus handshake keeps new starts away from a running access
    assert property (@(posedge mclk) disable iff (!reset_n)
        (ser.start_wr || ser.start_rd) |-> (state_q == IDLE));

endmodule

/* src/mbist_cfg_regs.sv */
// MBIST config registers with bus decode, ack timing, status packing and read mux
`timescale 1ns/100ps

module mbist_cfg_regs (
    input  logic                                   mclk,
    input  logic                                   reset_n,
    // Register bus
    input  logic                                   reg_cs,
    input  logic                                   reg_wr,
    input  logic [mbist_cfg_pkg::ADDR_W-1:0]       reg_addr,
    input  mbist_cfg_pkg::reg_word_t               reg_wdata,
    input  logic [mbist_cfg_pkg::BE_W-1:0]         reg_be,
    output mbist_cfg_pkg::reg_word_t               reg_rdata,
    output logic                                   reg_ack,
    // Channel status
    input  mbist_cfg_pkg::ch_vec_t                 bist_done,
    input  mbist_cfg_pkg::ch_vec_t                 bist_error,
    input  mbist_cfg_pkg::ch_vec_t                 bist_correct,
    input  logic [mbist_cfg_pkg::NUM_CH*mbist_cfg_pkg::ERR_CNT_W-1:0] bist_error_cnt,
    // Channel control
    output mbist_cfg_pkg::ch_vec_t                 bist_en,
    output mbist_cfg_pkg::ch_vec_t                 bist_run,
    output mbist_cfg_pkg::ch_vec_t                 bist_load,
    output logic [3:0]                             ser_sel,
    ser_access_if.host                             ser
);
    import mbist_cfg_pkg::*;

    logic [REG_IDX_W-1:0] sw_idx;
    logic                 cs_d;
    logic                 cs_first;
    logic                 wr_hit;
    logic                 ser_acc;
    logic                 dir_hit;
    reg_word_t            scratch0_q;
    reg_word_t            scratch1_q;
    reg_word_t            ctrl_q;
    reg_word_t            chip_id_q;
    reg_word_t            rel_date_q;
    reg_word_t            revision_q;
    reg_word_t            ser_last_q;
    logic [3:0]           sel_q;
    logic [2*DATA_W-1:0]  status_all;
    reg_word_t            rd_mux;

    // Byte lane merge under byte enables
    function automatic reg_word_t be_merge(input reg_word_t old_val,
                                           input reg_word_t new_val,
                                           input logic [BE_W-1:0] be);
        reg_word_t res;
        res = old_val;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    // ----------------------------------------------------------
    // Bus decode
    // ----------------------------------------------------------
    assign sw_idx   = reg_addr[5:2];
    // First cycle of a request only
    assign cs_first = reg_cs & ~cs_d;
    assign wr_hit   = cs_first & reg_wr;
    assign ser_acc  = (reg_wr & (sw_idx == REG_SER_WR)) | (~reg_wr & (sw_idx == REG_SER_RD));
    assign dir_hit  = cs_first & ~ser_acc;

    // Serial kick off
    assign ser.start_wr = cs_first & reg_wr & (sw_idx == REG_SER_WR);
    assign ser.start_rd = cs_first & ~reg_wr & (sw_idx == REG_SER_RD);
    assign ser.wdata    = reg_wdata;

    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            cs_d <= 1'b0;
        end else begin
            cs_d <= reg_cs;
        end
    end

    // ----------------------------------------------------------
    // Writable registers
    // ----------------------------------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            scratch0_q <= RST_SCRATCH0;
            scratch1_q <= RST_SCRATCH1;
            sel_q      <= '0;
            ctrl_q     <= '0;
            chip_id_q  <= RST_CHIP_ID;
            rel_date_q <= RST_REL_DATE;
            revision_q <= RST_REVISION;
        end else if (wr_hit) begin
            case (sw_idx)
                REG_SCRATCH0:  scratch0_q <= be_merge(scratch0_q, reg_wdata, reg_be);
                REG_SCRATCH1:  scratch1_q <= be_merge(scratch1_q, reg_wdata, reg_be);
                // Only the low nibble of lane 0 is kept
                REG_SER_SEL:   if (reg_be[0]) sel_q <= reg_wdata[3:0];
                REG_BIST_CTRL: ctrl_q     <= be_merge(ctrl_q, reg_wdata, reg_be);
                REG_CHIP_ID:   chip_id_q  <= be_merge(chip_id_q, reg_wdata, reg_be);
                REG_REL_DATE:  rel_date_q <= be_merge(rel_date_q, reg_wdata, reg_be);
                REG_REVISION:  revision_q <= be_merge(revision_q, reg_wdata, reg_be);
                default:       ;
            endcase
        end
    end

    assign ser_sel = sel_q;

    // ----------------------------------------------------------
    // Control split and status packing
    // ----------------------------------------------------------
    always_comb begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            // Nibble per channel with en run load in bits 0 to 2
            bist_en[ch]   = ctrl_q[4*ch];
            bist_run[ch]  = ctrl_q[4*ch+1];
            bist_load[ch] = ctrl_q[4*ch+2];
            // Status byte built from bit 0 upward
            status_all[8*ch +: 8] = {bist_error_cnt[ERR_CNT_W*ch +: ERR_CNT_W], 1'b0,
                                     bist_correct[ch], bist_error[ch], bist_done[ch]};
        end
    end

    // Read mux
    always_comb begin
        case (sw_idx)
            REG_SCRATCH0:  rd_mux = scratch0_q;
            REG_SCRATCH1:  rd_mux = scratch1_q;
            REG_SER_SEL:   rd_mux = {{(DATA_W-4){1'b0}}, sel_q};
            REG_BIST_CTRL: rd_mux = ctrl_q;
            REG_STATUS_LO: rd_mux = status_all[DATA_W-1:0];
            REG_STATUS_HI: rd_mux = status_all[2*DATA_W-1:DATA_W];
            REG_SER_LAST:  rd_mux = ser_last_q;
            REG_CHIP_ID:   rd_mux = chip_id_q;
            REG_REL_DATE:  rd_mux = rel_date_q;
            REG_REVISION:  rd_mux = revision_q;
            default:       rd_mux = '0;
        endcase
    end

    // ----------------------------------------------------------
    // Ack and read data
    // ----------------------------------------------------------
    // Direct access acks at once, serial access waits for done
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            reg_ack    <= 1'b0;
            ser_last_q <= '0;
        end else begin
            reg_ack <= dir_hit | ser.done;
            if (ser.done) begin
                ser_last_q <= ser.rdata;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (ser.done) begin
            reg_rdata <= ser.rdata;
        end else if (dir_hit) begin
            reg_rdata <= rd_mux;
        end
    end

    // Host must drop reg_cs after ack so ack never stretches
    assert property (@(posedge mclk) disable iff (!reset_n) reg_ack |=> !reg_ack);

endmodule

/* src/ser_access_if.sv */
// Serial access link between the register block and the serial engine
`timescale 1ns/100ps

interface ser_access_if;
    import mbist_cfg_pkg::*;

    // One-cycle start strobes from the register block
    logic      start_wr;
    logic      start_rd;
    // Word to shift out and word shifted in
    reg_word_t wdata;
    reg_word_t rdata;
    // One-cycle end of access strobe
    logic      done;

    modport host (
        output start_wr, start_rd, wdata,
        input  rdata, done
    );

    modport fsm (
        input  start_wr, start_rd,
        output done
    );

    modport shifter (
        input  wdata,
        output rdata
    );

endinterface

/* src/mbist_cfg_pkg.sv */
// MBIST config package with bus widths, register map, reset values and serial types
package mbist_cfg_pkg;

    // ----------------------------------------------------------
    // Register bus geometry
    // ----------------------------------------------------------
    localparam int DATA_W    = 32;
    localparam int BE_W      = 4;
    localparam int ADDR_W    = 8;
    // Word index comes from address bits 5 to 2
    localparam int REG_IDX_W = 4;

    // ----------------------------------------------------------
    // BIST channel side
    // ----------------------------------------------------------
    localparam int NUM_CH    = 8;
    localparam int ERR_CNT_W = 4;
    // One serial access moves a full word
    localparam int SHIFT_LEN = 32;
    localparam int CNT_W     = 5;

    // ----------------------------------------------------------
    // Register map
    // ----------------------------------------------------------
    localparam logic [REG_IDX_W-1:0] REG_SCRATCH0  = 4'd0;
    localparam logic [REG_IDX_W-1:0] REG_SCRATCH1  = 4'd1;
    localparam logic [REG_IDX_W-1:0] REG_SER_SEL   = 4'd2;
    localparam logic [REG_IDX_W-1:0] REG_BIST_CTRL = 4'd3;
    localparam logic [REG_IDX_W-1:0] REG_STATUS_LO = 4'd4;
    localparam logic [REG_IDX_W-1:0] REG_STATUS_HI = 4'd5;
    // Serial ports
    localparam logic [REG_IDX_W-1:0] REG_SER_WR    = 4'd6;
    localparam logic [REG_IDX_W-1:0] REG_SER_RD    = 4'd7;
    localparam logic [REG_IDX_W-1:0] REG_SER_LAST  = 4'd8;
    // Identification words
    localparam logic [REG_IDX_W-1:0] REG_CHIP_ID   = 4'd9;
    localparam logic [REG_IDX_W-1:0] REG_REL_DATE  = 4'd10;
    localparam logic [REG_IDX_W-1:0] REG_REVISION  = 4'd11;

    // ----------------------------------------------------------
    // Reset values
    // ----------------------------------------------------------
    localparam logic [DATA_W-1:0] RST_SCRATCH0 = 32'h4433_2211;
    localparam logic [DATA_W-1:0] RST_SCRATCH1 = 32'hDDCC_BBAA;
    // ASCII style chip tag
    localparam logic [DATA_W-1:0] RST_CHIP_ID  = 32'h4C66_8354;
    // Day month year
    localparam logic [DATA_W-1:0] RST_REL_DATE = 32'h0312_2021;
    localparam logic [DATA_W-1:0] RST_REVISION = 32'h0001_1000;

    // ----------------------------------------------------------
    // Types
    // ----------------------------------------------------------
    typedef logic [DATA_W-1:0] reg_word_t;
    typedef logic [NUM_CH-1:0] ch_vec_t;

    // Serial engine states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        SHIFT = 2'd1,
        DONE  = 2'd2
    } ser_state_t;

endpackage
